// ==== filelist.f ====
hw/RvDecodePkg.sv
hw/ControlUnit.sv
hw/ImmGen.sv
hw/RegFile.sv
hw/DecodeReg.sv
hw/DecodeTop.sv
bench/ClockGen.sv
bench/DecodeChecker.sv
bench/DecodeTop_props.sv
bench/DecodeTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= DecodeTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/DecodeTb.sv ====
`timescale 1ns/1ps

module DecodeTb;
    import RvDecodePkg::*;

    localparam int WaitLimit = 50;

    logic        clk;
    logic        rst;
    logic        rstReq;
    logic        inValid;
    logic        inReady;
    FetchPkt     inPkt;
    RegWb        intWb;
    RegWb        fltWb;
    logic        outValid;
    logic        outReady;
    DecodedInstr outInstr;
    int          readyMode; // 0 always ready, 1 random, 2 stalled
    int          timeouts;
    Word         pcCount;
    Opcode       opList [15];

    ClockGen clkGen (
        .rstReq (rstReq),
        .clk    (clk),
        .rst    (rst)
    );

    DecodeTop #(.IntZeroReg(1'b1), .FltZeroReg(1'b0)) dut_i (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inPkt    (inPkt),
        .intWb    (intWb),
        .fltWb    (fltWb),
        .outValid (outValid),
        .outReady (outReady),
        .outInstr (outInstr)
    );

    DecodeChecker chk (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inPkt    (inPkt),
        .intWb    (intWb),
        .fltWb    (fltWb),
        .outValid (outValid),
        .outReady (outReady),
        .outInstr (outInstr)
    );

    function automatic Word randInstr(input Opcode op);
        Word r;
        r = $urandom;
        return {r[31:7], op};
    endfunction

    function automatic RegWb randWb();
        RegWb w;
        w.en   = 1'($urandom_range(0, 1));
        w.addr = RegAddr'($urandom);
        w.data = $urandom;
        return w;
    endfunction

    task automatic waitResetDone();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst !== 1'b0 && n < WaitLimit);
        #1;
        if (rst !== 1'b0) begin
            timeouts++;
            $display("reset was never released");
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic writeBack(input int addr, input Word intData, input Word fltData);
        intWb = '{1'b1, RegAddr'(addr), intData};
        fltWb = '{1'b1, RegAddr'(addr), fltData};
        idle(1);
        intWb = '0;
        fltWb = '0;
    endtask

    // Write-backs stay on the ports until the instruction is accepted
    task automatic sendInstr(input Word instr, input RegWb iwb, input RegWb fwb);
        int   n;
        logic taken;
        if (timeouts != 0) begin
            return;
        end
        inValid     = 1'b1;
        inPkt.pc    = pcCount;
        inPkt.instr = instr;
        intWb       = iwb;
        fltWb       = fwb;
        n           = 0;
        taken       = 1'b0;
        while (!taken && n < WaitLimit) begin
            #1;
            taken = inReady; // Drives settle by mid-cycle
            @(posedge clk);
            #1;
            n++;
        end
        inValid = 1'b0;
        intWb   = '0;
        fltWb   = '0;
        pcCount = pcCount + 32'd4;
        if (!taken) begin
            timeouts++;
            $display("inReady stayed low for %0d cycles, the input handshake stalled", n);
        end
    endtask

    task automatic drain();
        int n;
        readyMode = 0;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (outValid !== 1'b0 && n < WaitLimit);
        if (outValid !== 1'b0) begin
            timeouts++;
            $display("outValid never dropped while draining the pipeline");
        end
    endtask

    task automatic pulseReset();
        rstReq = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rstReq = 1'b0;
    endtask

    initial begin
        int mode;
        outReady = 1'b0;
        forever begin
            @(posedge clk);
            mode = readyMode;
            #1;
            case (mode)
                0:       outReady = 1'b1;
                1:       outReady = 1'($urandom_range(0, 1));
                default: outReady = 1'b0;
            endcase
        end
    end

    initial begin
        int   i;
        Word  instr;
        RegWb iwb;
        RegWb fwb;
        void'($urandom(32'h0fef_4705));
        rstReq    = 1'b0;
        inValid   = 1'b0;
        inPkt     = '0;
        intWb     = '0;
        fltWb     = '0;
        readyMode = 0;
        timeouts  = 0;
        pcCount   = 32'h0000_1000;
        opList    = '{OpcodeOp, OpcodeLoad, OpcodeOpImm, OpcodeJalr, OpcodeStore,
                      OpcodeBranch, OpcodeAuipc, OpcodeLui, OpcodeJal, OpcodeSystem,
                      OpcodeFlw, OpcodeFsw, OpcodeOpFp, 7'b1111111, 7'b0001011};
        waitResetDone();

        for (i = 0; i < 32; i++) begin
            writeBack(i, $urandom, $urandom); // x0 write dropped and f0 kept
        end
        for (i = 0; i < 30; i++) begin
            instr     = randInstr(opList[i % 15]);
            instr[31] = i[0]; // Each opcode with both sign bits
            sendInstr(instr, '0, '0);
        end

        instr        = randInstr(OpcodeOpFp);
        instr[24:15] = '0; // x0 and f0 as sources
        sendInstr(instr, '0, '0);

        instr    = randInstr(OpcodeOp);
        if (instr[19:15] == 5'd0) begin
            instr[19:15] = 5'd1; // x0 would hide the forward
        end
        iwb      = '{1'b1, instr[19:15], $urandom};
        fwb      = '{1'b1, instr[24:20], $urandom};
        sendInstr(instr, iwb, fwb);

        readyMode = 1;
        for (i = 0; i < 120; i++) begin
            sendInstr(randInstr(opList[$urandom_range(0, 14)]), randWb(), randWb());
            idle($urandom_range(0, 2));
        end

        drain();
        readyMode = 2;
        sendInstr(randInstr(OpcodeLoad), '0, '0);
        idle(3);
        pulseReset(); // Bundle still in flight
        readyMode = 1;
        for (i = 0; i < 40; i++) begin
            sendInstr(randInstr(opList[$urandom_range(0, 14)]), '0, '0);
        end

        drain();
        chk.finishCheck();
        $display("checked %0d bundles: %0d mismatches, %0d other errors, %0d timeouts",
                 chk.checkedCount, chk.mismatchCount, chk.otherCount, timeouts);
        if (chk.mismatchCount == 0 && chk.otherCount == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== bench/DecodeTop_props.sv ====
`timescale 1ns/1ps

module DecodeTop_props (
    input logic                     clk,
    input logic                     rst,
    input logic                     inReady,
    input logic                     outValid,
    input logic                     outReady,
    input RvDecodePkg::DecodedInstr outInstr
);

    property validClearedByReset;
        @(posedge clk) rst |=> !outValid;
    endproperty

    property holdWhileStalled;
        @(posedge clk) disable iff (rst)
            (outValid && !outReady) |=> (outValid && $stable(outInstr));
    endproperty

    property readyRule;
        @(posedge clk) disable iff (rst) inReady == (!outValid || outReady);
    endproperty

    assert property (validClearedByReset)
        else $error("outValid is high in the cycle after reset");
    assert property (holdWhileStalled)
        else $error("output bundle changed while stalled");
    assert property (readyRule)
        else $error("inReady does not follow outValid and outReady");

endmodule

bind DecodeTop DecodeTop_props handshakeProps (
    .clk      (clk),
    .rst      (rst),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outInstr (outInstr)
);

// ==== bench/DecodeChecker.sv ====
`timescale 1ns/1ps

module DecodeChecker (
    input logic                     clk,
    input logic                     rst,
    input logic                     inValid,
    input logic                     inReady,
    input RvDecodePkg::FetchPkt     inPkt,
    input RvDecodePkg::RegWb        intWb,
    input RvDecodePkg::RegWb        fltWb,
    input logic                     outValid,
    input logic                     outReady,
    input RvDecodePkg::DecodedInstr outInstr
);
    import RvDecodePkg::*;

    Word         intShadow [32];
    Word         fltShadow [32];
    DecodedInstr expQ [$];
    logic        prevRst = 1'b0;
    int          mismatchCount = 0;
    int          otherCount = 0;
    int          checkedCount = 0;

    function automatic CtrlBundle refCtrl(input Opcode op);
        // aluOp, {aluSrc pcToRegSrc}, immType, {rdSrc memToReg memWrite memRead regWrite},
        // branch, {regWriteF aluSelF memoryInF}
        case (op)
            OpcodeOp:     return {AluR,      2'b10, ImmNone, 5'b01001, BrNone, 3'b011};
            OpcodeLoad:   return {AluAdd,    2'b00, ImmI,    5'b00011, BrNone, 3'b011};
            OpcodeOpImm:  return {AluImm,    2'b00, ImmI,    5'b01001, BrNone, 3'b011};
            OpcodeJalr:   return {AluAdd,    2'b00, ImmI,    5'b11001, BrJalr, 3'b011};
            OpcodeStore:  return {AluAdd,    2'b00, ImmS,    5'b00100, BrNone, 3'b011};
            OpcodeBranch: return {AluBranch, 2'b11, ImmB,    5'b10000, BrCond, 3'b011};
            OpcodeAuipc:  return {AluAdd,    2'b01, ImmU,    5'b11001, BrNone, 3'b011};
            OpcodeLui:    return {AluLui,    2'b00, ImmU,    5'b01001, BrNone, 3'b011};
            OpcodeJal:    return {AluAdd,    2'b00, ImmJ,    5'b11001, BrJal,  3'b011};
            OpcodeSystem: return {AluCsr,    2'b00, ImmI,    5'b00001, BrNone, 3'b011};
            OpcodeFlw:    return {AluAdd,    2'b00, ImmI,    5'b00010, BrNone, 3'b101};
            OpcodeFsw:    return {AluAdd,    2'b00, ImmS,    5'b00100, BrNone, 3'b000};
            OpcodeOpFp:   return {AluFlt,    2'b00, ImmI,    5'b01000, BrNone, 3'b101};
            default:      return {AluAdd,    2'b00, ImmI,    5'b00000, BrNone, 3'b011};
        endcase
    endfunction

    function automatic Word refImm(input Word instr, input ImmType kind);
        Word iImm;
        Word sImm;
        iImm = Word'($signed(instr) >>> 20);
        sImm = {iImm[31:5], instr[11:7]}; // S shares the upper bits with I
        case (kind)
            ImmI:    return iImm;
            ImmS:    return sImm;
            ImmB:    return {sImm[31:12], instr[7], sImm[10:1], 1'b0};
            ImmU:    return instr & 32'hffff_f000;
            ImmJ:    return {iImm[31:20], instr[19:12], instr[20], instr[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    // Shadow read with the write-back of this edge applied first
    function automatic Word readSrc(input logic flt, input RegAddr addr);
        if (flt) begin
            return (fltWb.en && fltWb.addr == addr) ? fltWb.data : fltShadow[addr];
        end
        if (addr == 5'd0) begin
            return '0;
        end
        return (intWb.en && intWb.addr == addr) ? intWb.data : intShadow[addr];
    endfunction

    function automatic DecodedInstr refDecode(input FetchPkt pkt);
        DecodedInstr d;
        d.ctrl   = refCtrl(pkt.instr[6:0]);
        d.pc     = pkt.pc;
        d.imm    = refImm(pkt.instr, d.ctrl.immType);
        d.rd     = pkt.instr[11:7];
        d.rs1    = pkt.instr[19:15];
        d.rs2    = pkt.instr[24:20];
        d.funct3 = pkt.instr[14:12];
        d.funct7 = pkt.instr[31:25];
        d.rs1Int = readSrc(1'b0, d.rs1);
        d.rs2Int = readSrc(1'b0, d.rs2);
        d.rs1Flt = readSrc(1'b1, d.rs1);
        d.rs2Flt = readSrc(1'b1, d.rs2);
        return d;
    endfunction

    task automatic checkField(input string name, input Word got, input Word expected);
        if (got !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic compareBundle(input DecodedInstr got, input DecodedInstr expected);
        checkField("ctrl", Word'(got.ctrl), Word'(expected.ctrl));
        checkField("pc", got.pc, expected.pc);
        checkField("imm", got.imm, expected.imm);
        checkField("rd", Word'(got.rd), Word'(expected.rd));
        checkField("rs1", Word'(got.rs1), Word'(expected.rs1));
        checkField("rs2", Word'(got.rs2), Word'(expected.rs2));
        checkField("funct3", Word'(got.funct3), Word'(expected.funct3));
        checkField("funct7", Word'(got.funct7), Word'(expected.funct7));
        checkField("rs1Int", got.rs1Int, expected.rs1Int);
        checkField("rs2Int", got.rs2Int, expected.rs2Int);
        checkField("rs1Flt", got.rs1Flt, expected.rs1Flt);
        checkField("rs2Flt", got.rs2Flt, expected.rs2Flt);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            expQ.delete(); // In-flight bundles are dropped
            for (int i = 0; i < 32; i++) begin
                intShadow[i] = '0;
                fltShadow[i] = '0;
            end
        end else begin
            if (prevRst && (outValid !== 1'b0 || inReady !== 1'b1)) begin
                otherCount++;
                $display("at %0t after reset outValid is not low or inReady is not high", $time);
            end
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    otherCount++;
                    $display("at %0t a bundle came out while none was expected", $time);
                end else begin
                    compareBundle(outInstr, expQ.pop_front());
                    checkedCount++;
                end
            end
            if (inValid && inReady) begin
                expQ.push_back(refDecode(inPkt));
            end
            if (intWb.en && intWb.addr != 5'd0) begin
                intShadow[intWb.addr] = intWb.data;
            end
            if (fltWb.en) begin
                fltShadow[fltWb.addr] = fltWb.data; // f0 is an ordinary register
            end
        end
        prevRst = rst;
    end

    task automatic finishCheck();
        if (expQ.size() != 0) begin
            otherCount++;
            $display("%0d expected bundles never came out", expQ.size());
        end
        if (checkedCount == 0) begin
            otherCount++;
            $display("no bundle was checked");
        end
    endtask

endmodule

// ==== bench/ClockGen.sv ====
`timescale 1ns/1ps

module ClockGen (
    input  logic rstReq,
    output logic clk,
    output logic rst
);

    logic porRst;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        porRst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        porRst = 1'b0;
    end

    assign rst = porRst || rstReq; // Power-on or requested reset

endmodule

// ==== hw/DecodeTop.sv ====
`timescale 1ns/1ps

module DecodeTop #(
    parameter bit IntZeroReg = 1'b1,
    parameter bit FltZeroReg = 1'b0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inValid,
    output logic                     inReady,
    input  RvDecodePkg::FetchPkt     inPkt,
    input  RvDecodePkg::RegWb        intWb,
    input  RvDecodePkg::RegWb        fltWb,
    output logic                     outValid,
    input  logic                     outReady,
    output RvDecodePkg::DecodedInstr outInstr
);
    import RvDecodePkg::*;

    Word         instr;
    Opcode       opcode;
    RegAddr      rs1;
    RegAddr      rs2;
    CtrlBundle   ctrl;
    Word         imm;
    Word         rs1Int;
    Word         rs2Int;
    Word         rs1Flt;
    Word         rs2Flt;
    DecodedInstr decoded;

    assign instr  = inPkt.instr;
    assign opcode = instr[6:0];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    ControlUnit ctrlUnit (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    ImmGen immGen (
        .instr   (instr),
        .immType (ctrl.immType),
        .imm     (imm)
    );

    RegFile #(.ZeroReg(IntZeroReg)) intRegs (
        .clk (clk),
        .rst (rst),
        .rs1 (rs1),
        .rs2 (rs2),
        .wb  (intWb),
        .rd1 (rs1Int),
        .rd2 (rs2Int)
    );

    RegFile #(.ZeroReg(FltZeroReg)) fltRegs ( // f0 is a normal register
        .clk (clk),
        .rst (rst),
        .rs1 (rs1),
        .rs2 (rs2),
        .wb  (fltWb),
        .rd1 (rs1Flt),
        .rd2 (rs2Flt)
    );

    always_comb begin
        decoded.ctrl   = ctrl;
        decoded.pc     = inPkt.pc;
        decoded.imm    = imm;
        decoded.rd     = instr[11:7];
        decoded.rs1    = rs1;
        decoded.rs2    = rs2;
        decoded.funct3 = instr[14:12];
        decoded.funct7 = instr[31:25];
        decoded.rs1Int = rs1Int;
        decoded.rs2Int = rs2Int;
        decoded.rs1Flt = rs1Flt;
        decoded.rs2Flt = rs2Flt;
    end

    DecodeReg outReg (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (decoded),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outInstr)
    );

endmodule

// ==== hw/DecodeReg.sv ====
`timescale 1ns/1ps

module DecodeReg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inValid,
    output logic                     inReady,
    input  RvDecodePkg::DecodedInstr inData,
    output logic                     outValid,
    input  logic                     outReady,
    output RvDecodePkg::DecodedInstr outData
);

    logic accept;

    // Slot is free when empty or draining this cycle
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outData <= inData; // Held while stalled
        end
    end

endmodule

// ==== hw/RegFile.sv ====
`timescale 1ns/1ps

module RegFile #(
    parameter bit ZeroReg = 1'b1
) (
    input  logic                clk,
    input  logic                rst,
    input  RvDecodePkg::RegAddr rs1,
    input  RvDecodePkg::RegAddr rs2,
    input  RvDecodePkg::RegWb   wb,
    output RvDecodePkg::Word    rd1,
    output RvDecodePkg::Word    rd2
);
    import RvDecodePkg::*;

    Word  regs [32];
    logic wrOk;

    // Writes to x0 are dropped when it is hardwired
    assign wrOk = wb.en && !(ZeroReg && (wb.addr == 5'd0));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrOk) begin
            regs[wb.addr] <= wb.data;
        end
    end

    always_comb begin
        if (ZeroReg && (rs1 == 5'd0)) begin
            rd1 = '0;
        end else if (wrOk && (wb.addr == rs1)) begin
            rd1 = wb.data; // Same-edge forward
        end else begin
            rd1 = regs[rs1];
        end

        if (ZeroReg && (rs2 == 5'd0)) begin
            rd2 = '0;
        end else if (wrOk && (wb.addr == rs2)) begin
            rd2 = wb.data;
        end else begin
            rd2 = regs[rs2];
        end
    end

endmodule

// ==== hw/ImmGen.sv ====
`timescale 1ns/1ps

module ImmGen (
    input  RvDecodePkg::Word    instr,
    input  RvDecodePkg::ImmType immType,
    output RvDecodePkg::Word    imm
);
    import RvDecodePkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immType)
            ImmI: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            ImmS: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            ImmB: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0}; // Halfword aligned offset
            end
            ImmU: begin
                imm = {instr[31:12], 12'b0};
            end
            ImmJ: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // ImmNone and unused codes
            end
        endcase
    end

endmodule

// ==== hw/ControlUnit.sv ====
`timescale 1ns/1ps

module ControlUnit (
    input  RvDecodePkg::Opcode     opcode,
    output RvDecodePkg::CtrlBundle ctrl
);
    import RvDecodePkg::*;

    always_comb begin
        // Default row first and each opcode overrides what differs
        ctrl           = '0;
        ctrl.aluOp     = AluAdd;
        ctrl.immType   = ImmI;
        ctrl.branch    = BrNone;
        ctrl.aluSelF   = 1'b1;
        ctrl.memoryInF = 1'b1;

        case (opcode)
            OpcodeOp: begin
                ctrl.aluOp    = AluR;
                ctrl.aluSrc   = 1'b1;
                ctrl.immType  = ImmNone;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OpcodeLoad: begin
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OpcodeOpImm: begin
                ctrl.aluOp    = AluImm;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OpcodeJalr: begin
                ctrl.rdSrc    = 1'b1; // Link address to rd
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.branch   = BrJalr;
            end
            OpcodeStore: begin
                ctrl.immType  = ImmS;
                ctrl.memWrite = 1'b1;
            end
            OpcodeBranch: begin
                ctrl.aluOp      = AluBranch;
                ctrl.aluSrc     = 1'b1;
                ctrl.pcToRegSrc = 1'b1;
                ctrl.immType    = ImmB;
                ctrl.rdSrc      = 1'b1;
                ctrl.branch     = BrCond;
            end
            OpcodeAuipc: begin
                ctrl.pcToRegSrc = 1'b1; // PC plus immediate
                ctrl.immType    = ImmU;
                ctrl.rdSrc      = 1'b1;
                ctrl.memToReg   = 1'b1;
                ctrl.regWrite   = 1'b1;
            end
            OpcodeLui: begin
                ctrl.aluOp    = AluLui;
                ctrl.immType  = ImmU;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OpcodeJal: begin
                ctrl.immType  = ImmJ;
                ctrl.rdSrc    = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.branch   = BrJal;
            end
            OpcodeSystem: begin
                ctrl.aluOp    = AluCsr;
                ctrl.regWrite = 1'b1;
            end
            OpcodeFlw: begin
                ctrl.memRead   = 1'b1;
                ctrl.regWriteF = 1'b1; // Loads into the float file
                ctrl.aluSelF   = 1'b0;
            end
            OpcodeFsw: begin
                ctrl.immType   = ImmS;
                ctrl.memWrite  = 1'b1;
                ctrl.aluSelF   = 1'b0;
                ctrl.memoryInF = 1'b0; // Store data from rs2 float
            end
            OpcodeOpFp: begin
                ctrl.aluOp     = AluFlt; // FADD.S and FSUB.S
                ctrl.memToReg  = 1'b1;
                ctrl.regWriteF = 1'b1;
                ctrl.aluSelF   = 1'b0;
            end
            default: begin
                // Unknown opcode keeps the default row
            end
        endcase
    end

endmodule

// ==== hw/RvDecodePkg.sv ====
package RvDecodePkg;

    typedef logic [31:0] Word;
    typedef logic [4:0]  RegAddr;
    typedef logic [6:0]  Opcode;
    typedef logic [2:0]  AluOp;
    typedef logic [2:0]  ImmType;
    typedef logic [1:0]  BranchKind;

    localparam Opcode OpcodeOp     = 7'b0110011;
    localparam Opcode OpcodeLoad   = 7'b0000011;
    localparam Opcode OpcodeOpImm  = 7'b0010011;
    localparam Opcode OpcodeJalr   = 7'b1100111;
    localparam Opcode OpcodeStore  = 7'b0100011;
    localparam Opcode OpcodeBranch = 7'b1100011;
    localparam Opcode OpcodeAuipc  = 7'b0010111;
    localparam Opcode OpcodeLui    = 7'b0110111;
    localparam Opcode OpcodeJal    = 7'b1101111;
    localparam Opcode OpcodeSystem = 7'b1110011;
    localparam Opcode OpcodeFlw    = 7'b0000111;
    localparam Opcode OpcodeFsw    = 7'b0100111;
    localparam Opcode OpcodeOpFp   = 7'b1010011;

    localparam AluOp AluR      = 3'd0;
    localparam AluOp AluImm    = 3'd1;
    localparam AluOp AluBranch = 3'd2;
    localparam AluOp AluLui    = 3'd3;
    localparam AluOp AluCsr    = 3'd4;
    localparam AluOp AluFlt    = 3'd5;
    localparam AluOp AluAdd    = 3'd6; // Address add, also the no-op class

    localparam ImmType ImmI    = 3'd0;
    localparam ImmType ImmS    = 3'd1;
    localparam ImmType ImmB    = 3'd2;
    localparam ImmType ImmU    = 3'd3;
    localparam ImmType ImmJ    = 3'd4;
    localparam ImmType ImmNone = 3'd5;

    localparam BranchKind BrNone = 2'd0;
    localparam BranchKind BrJalr = 2'd1;
    localparam BranchKind BrCond = 2'd2;
    localparam BranchKind BrJal  = 2'd3;

    typedef struct packed {
        AluOp      aluOp;
        logic      aluSrc;
        logic      pcToRegSrc;
        ImmType    immType;
        logic      rdSrc;
        logic      memToReg;
        logic      memWrite;
        logic      memRead;
        logic      regWrite;
        BranchKind branch;
        logic      regWriteF;  // Float file write
        logic      aluSelF;    // 0 picks the float ALU
        logic      memoryInF;  // 0 stores float data
    } CtrlBundle;

    typedef struct packed {
        CtrlBundle  ctrl;
        Word        pc;
        Word        imm;
        RegAddr     rd;
        RegAddr     rs1;
        RegAddr     rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        Word        rs1Int;
        Word        rs2Int;
        Word        rs1Flt;
        Word        rs2Flt;
    } DecodedInstr;

    typedef struct packed {
        Word pc;
        Word instr;
    } FetchPkt;

    typedef struct packed {
        logic   en;
        RegAddr addr;
        Word    data;
    } RegWb;

endpackage
